/* umtrx_ctrl_pkg.sv */
// Bus widths and data types of the control core
// Settings register map, readback regions and compatibility number
// Boot state enum
package umtrx_ctrl_pkg;

   ////////////////////
   // Widths and types

   localparam int wb_dw  = 32;  // Wishbone data width
   localparam int wb_aw  = 16;  // Byte addresses, 64K space
   localparam int set_aw = 8;   // Settings word index

   typedef logic [set_aw-1:0] set_addr_t;
   typedef logic [wb_dw-1:0]  set_data_t;
   typedef logic [wb_dw-1:0]  wb_data_t;
   typedef logic [wb_aw-1:0]  wb_addr_t;
   typedef logic [63:0]       vita_time_t;  // Seconds high, ticks low

   // Bootloader handover
   typedef enum logic [0:0] {
      BOOT_WAIT = 1'b0,  // Bootloader running
      BOOT_DONE = 1'b1   // Handed over, stays until power-on reset
   } boot_state_t;

   ////////////////////
   // Settings register map

   localparam int SR_MISC_DEF   = 0;    // Misc board control
   localparam int SR_TIME64_DEF = 10;   // VITA time
   localparam int SR_DIVSW_DEF  = 180;  // Diversity switches

   localparam int OFS_CLK  = 0;  // Clock control, LMS resets in bits 6:5
   localparam int OFS_LED  = 3;
   localparam int OFS_PHY  = 4;  // Active high PHY reset
   localparam int OFS_BLDR = 5;  // Bootloader done

   localparam int OFS_TIME_HI  = 0;
   localparam int OFS_TIME_LO  = 1;  // Write here triggers the load
   localparam int OFS_TIME_IMM = 2;  // Bit 0 selects now or next PPS

   localparam int OFS_DIVSW1 = 0;
   localparam int OFS_DIVSW2 = 1;

   // Bump when the register map changes
   localparam wb_data_t COMPAT_NUM_DEF = {16'd9, 16'd0};  // Major, minor

   ////////////////////
   // Wishbone regions

   localparam wb_addr_t SETTINGS_REGION = 16'h7000;
   localparam wb_addr_t SETTINGS_MASK   = 16'hF000;  // 4K window
   localparam wb_addr_t READBACK_REGION = 16'h5C00;
   localparam wb_addr_t READBACK_MASK   = 16'hFC00;  // 1K window

endpackage

/* boot_reset_ctrl.sv */
// Bootloader reset controller
// Turns power-on reset and the bootloader-done flag into the bus reset
`timescale 1ns/1ps

module boot_reset_ctrl (
   input  logic                        wb_clk,
   input  logic                        por_rst,
   input  logic                        bldr_done_i,   // From settings register
   output logic                        bus_rst_o,
   output umtrx_ctrl_pkg::boot_state_t boot_state_o
);
   import umtrx_ctrl_pkg::*;

   boot_state_t state_q;
   logic        bus_rst_q;

   ////////////////////
   // Handover FSM

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state_q   <= BOOT_WAIT;
         bus_rst_q <= 1'b1;        // Held through power-on, one extra cycle after
      end else begin
         case (state_q)
            BOOT_WAIT: begin
               bus_rst_q <= 1'b0;
               if (bldr_done_i) begin
                  // Bootloader finished, reset the bus once for the main image
                  state_q   <= BOOT_DONE;
                  bus_rst_q <= 1'b1;
               end
            end
            BOOT_DONE: begin
               bus_rst_q <= 1'b0;  // Only por_rst leaves this state
            end
            default: begin
               state_q   <= BOOT_WAIT;
               bus_rst_q <= 1'b1;
            end
         endcase
      end
   end

   assign bus_rst_o    = bus_rst_q;
   assign boot_state_o = state_q;

   // Handover is one-way until the next power-on
   a_done_sticky: assert property (@(posedge wb_clk)
      (state_q == BOOT_DONE && !por_rst) |=> (state_q == BOOT_DONE))
      else $error("boot state left BOOT_DONE without por_rst");

endmodule

/* vita_timer.sv */
// 64-bit VITA time counter
// Settings-bus load, immediate or on the next PPS edge
// PPS synchronizer, edge detect and time capture
`timescale 1ns/1ps

module vita_timer #(
   parameter int TIME_BASE = umtrx_ctrl_pkg::SR_TIME64_DEF
) (
   input  logic                       wb_clk,
   input  logic                       bus_rst_i,
   input  logic                       pps_i,           // Asynchronous
   input  logic                       set_stb_i,
   input  umtrx_ctrl_pkg::set_addr_t  set_addr_i,
   input  umtrx_ctrl_pkg::set_data_t  set_data_i,
   output umtrx_ctrl_pkg::vita_time_t vita_time_o,
   output umtrx_ctrl_pkg::vita_time_t vita_time_pps_o
);
   import umtrx_ctrl_pkg::*;

   localparam set_addr_t ADDR_HI  = set_addr_t'(TIME_BASE + OFS_TIME_HI);
   localparam set_addr_t ADDR_LO  = set_addr_t'(TIME_BASE + OFS_TIME_LO);
   localparam set_addr_t ADDR_IMM = set_addr_t'(TIME_BASE + OFS_TIME_IMM);

   logic [31:0] time_hi_q;     // Shadow of the high half
   logic [31:0] time_lo_q;     // Low half kept for an armed load
   logic        imm_q;         // Load now instead of at PPS
   logic        armed_q;       // Load waiting for PPS
   logic [1:0]  pps_sync_q;
   logic        pps_dly_q;
   logic        pps_edge;
   logic        lo_now;
   logic        lo_arm;
   vita_time_t  time_q;
   vita_time_t  time_pps_q;

   assign lo_now   = set_stb_i && (set_addr_i == ADDR_LO) && imm_q;
   assign lo_arm   = set_stb_i && (set_addr_i == ADDR_LO) && !imm_q;
   assign pps_edge = pps_sync_q[1] & ~pps_dly_q;  // Rising edge, acted on next clock

   ////////////////////
   // Settings writes

   always_ff @(posedge wb_clk) begin  // Load value
      if (set_stb_i && set_addr_i == ADDR_HI) time_hi_q <= set_data_i;
      if (lo_arm) time_lo_q <= set_data_i;
   end

   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) begin
         imm_q   <= 1'b0;
         armed_q <= 1'b0;
      end else begin
         if (set_stb_i && set_addr_i == ADDR_IMM) imm_q <= set_data_i[0];
         if (pps_edge) armed_q <= 1'b0;  // Armed load consumed
         if (lo_arm) armed_q <= 1'b1;    // New arm wins over the clear
      end
   end

   ////////////////////
   // PPS and counter

   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) begin
         pps_sync_q <= 2'b00;
         pps_dly_q  <= 1'b0;
         time_q     <= '0;
         time_pps_q <= '0;
      end else begin
         pps_sync_q <= {pps_sync_q[0], pps_i};  // Two-flop synchronizer
         pps_dly_q  <= pps_sync_q[1];
         time_q     <= time_q + 64'd1;          // One tick per clock
         if (pps_edge) begin
            if (armed_q) begin
               time_q     <= {time_hi_q, time_lo_q};
               time_pps_q <= {time_hi_q, time_lo_q};
            end else begin
               time_pps_q <= time_q;            // Snapshot at the edge
            end
         end
         if (lo_now) time_q <= {time_hi_q, set_data_i};
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = time_pps_q;

   // A PPS edge always consumes the armed load unless re-armed in the same cycle
   a_arm_cleared: assert property (@(posedge wb_clk) disable iff (bus_rst_i)
      (pps_edge && !lo_arm) |=> !armed_q)
      else $error("armed load survived a PPS edge");

endmodule

/* settings_regs.sv */
// Wishbone to settings-bus strobe generator
// Board control registers for LMS reset, PHY reset, LEDs,
// diversity switches and the bootloader-done flag
`timescale 1ns/1ps

module settings_regs #(
   parameter int MISC_BASE  = umtrx_ctrl_pkg::SR_MISC_DEF,
   parameter int DIVSW_BASE = umtrx_ctrl_pkg::SR_DIVSW_DEF
) (
   input  logic                      wb_clk,
   input  logic                      bus_rst_i,
   input  umtrx_ctrl_pkg::wb_addr_t  wb_adr_i,
   input  umtrx_ctrl_pkg::wb_data_t  wb_dat_i,
   input  logic                      wb_we_i,
   input  logic                      sel_i,        // Request decoded to this region
   output logic                      wb_ack_o,
   output logic                      set_stb_o,
   output umtrx_ctrl_pkg::set_addr_t set_addr_o,
   output umtrx_ctrl_pkg::set_data_t set_data_o,
   output logic [7:0]                leds_o,
   output logic [1:0]                lms_res_o,
   output logic                      phy_resetn_o,
   output logic                      divsw1_o,
   output logic                      divsw2_o,
   output logic                      bldr_done_o
);
   import umtrx_ctrl_pkg::*;

   localparam set_addr_t ADDR_CLK    = set_addr_t'(MISC_BASE + OFS_CLK);
   localparam set_addr_t ADDR_LED    = set_addr_t'(MISC_BASE + OFS_LED);
   localparam set_addr_t ADDR_PHY    = set_addr_t'(MISC_BASE + OFS_PHY);
   localparam set_addr_t ADDR_BLDR   = set_addr_t'(MISC_BASE + OFS_BLDR);
   localparam set_addr_t ADDR_DIVSW1 = set_addr_t'(DIVSW_BASE + OFS_DIVSW1);
   localparam set_addr_t ADDR_DIVSW2 = set_addr_t'(DIVSW_BASE + OFS_DIVSW2);

   logic       ack_q;
   logic       set_stb_q;
   set_addr_t  set_addr_q;
   set_data_t  set_data_q;
   logic       new_req;      // First cycle of a request
   logic       wr_req;
   set_addr_t  req_addr;     // Word index

   logic [1:0] lms_res_q;    // Bits 6:5 of clock control
   logic [7:0] led_q;
   logic       phy_rst_q;
   logic       bldr_q;
   logic       divsw1_q;
   logic       divsw2_q;

   assign new_req  = sel_i & ~ack_q;  // Ack drops even if stb is held
   assign wr_req   = new_req & wb_we_i;
   assign req_addr = wb_adr_i[set_aw+1:2];

   ////////////////////
   // Ack and strobe

   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) begin
         ack_q     <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         ack_q     <= new_req;
         set_stb_q <= wr_req;     // Same cycle as ack
      end
   end

   always_ff @(posedge wb_clk) begin
      if (wr_req) begin
         set_addr_q <= req_addr;
         set_data_q <= wb_dat_i;
      end
   end

   ////////////////////
   // Board registers

   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) begin
         lms_res_q <= 2'b00;
         led_q     <= 8'h00;
         phy_rst_q <= 1'b0;       // PHY running
         bldr_q    <= 1'b0;
         divsw1_q  <= 1'b1;
         divsw2_q  <= 1'b1;
      end else if (wr_req) begin
         case (req_addr)
            ADDR_CLK:    lms_res_q <= wb_dat_i[6:5];
            ADDR_LED:    led_q     <= wb_dat_i[7:0];
            ADDR_PHY:    phy_rst_q <= wb_dat_i[0];
            ADDR_BLDR:   bldr_q    <= wb_dat_i[0];
            ADDR_DIVSW1: divsw1_q  <= wb_dat_i[0];
            ADDR_DIVSW2: divsw2_q  <= wb_dat_i[0];
            default: ;            // Other words only go out on the bus
         endcase
      end
   end

   assign wb_ack_o     = ack_q;
   assign set_stb_o    = set_stb_q;
   assign set_addr_o   = set_addr_q;
   assign set_data_o   = set_data_q;
   assign leds_o       = led_q;    // Software value only
   assign lms_res_o    = lms_res_q;
   assign phy_resetn_o = ~phy_rst_q;
   assign divsw1_o     = divsw1_q;
   assign divsw2_o     = divsw2_q;
   assign bldr_done_o  = bldr_q;

   // Single-cycle accesses only
   a_ack_single: assert property (@(posedge wb_clk) disable iff (bus_rst_i)
      ack_q |=> !ack_q)
      else $error("settings ack high two cycles running");

endmodule

/* readback_mux.sv */
// Sixteen-word Wishbone readback
// Time, PPS time, compatibility number and board status
`timescale 1ns/1ps

module readback_mux #(
   parameter umtrx_ctrl_pkg::wb_data_t COMPAT_NUM = umtrx_ctrl_pkg::COMPAT_NUM_DEF
) (
   input  logic                       wb_clk,
   input  logic                       bus_rst_i,
   input  logic                       sel_i,
   input  umtrx_ctrl_pkg::wb_addr_t   wb_adr_i,
   input  umtrx_ctrl_pkg::vita_time_t vita_time_i,
   input  umtrx_ctrl_pkg::vita_time_t vita_time_pps_i,
   input  logic [2:0]                 status_bits_i,  // aux_ld2, aux_ld1, button
   output umtrx_ctrl_pkg::wb_data_t   wb_dat_o,
   output logic                       wb_ack_o
);
   import umtrx_ctrl_pkg::*;

   logic     ack_q;
   logic     new_req;
   wb_data_t word_sel;
   wb_data_t dat_q;

   assign new_req = sel_i & ~ack_q;

   // Word index from address bits 5:2
   always_comb begin
      case (wb_adr_i[5:2])
         4'd10:   word_sel = vita_time_i[63:32];
         4'd11:   word_sel = vita_time_i[31:0];
         4'd12:   word_sel = COMPAT_NUM;
         4'd13:   word_sel = {13'd0, status_bits_i, 16'd0};
         4'd14:   word_sel = vita_time_pps_i[63:32];
         4'd15:   word_sel = vita_time_pps_i[31:0];
         default: word_sel = '0;  // Unused words
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (bus_rst_i) ack_q <= 1'b0;
      else           ack_q <= new_req;
   end

   always_ff @(posedge wb_clk) begin
      if (new_req) dat_q <= word_sel;  // Valid together with ack
   end

   assign wb_dat_o = dat_q;
   assign wb_ack_o = ack_q;

   // No ack without a request
   a_ack_req: assert property (@(posedge wb_clk) disable iff (bus_rst_i)
      ack_q |-> $past(sel_i))
      else $error("readback ack without request");

endmodule

/* umtrx_ctrl_top.sv */
// Control core top level
// Wishbone region decode, unmapped-address ack, ack and read data merge
// Reset controller, settings registers, VITA timer and readback instances
`timescale 1ns/1ps

module umtrx_ctrl_top #(
   parameter int                       MISC_BASE  = umtrx_ctrl_pkg::SR_MISC_DEF,
   parameter int                       TIME_BASE  = umtrx_ctrl_pkg::SR_TIME64_DEF,
   parameter int                       DIVSW_BASE = umtrx_ctrl_pkg::SR_DIVSW_DEF,
   parameter umtrx_ctrl_pkg::wb_data_t COMPAT_NUM = umtrx_ctrl_pkg::COMPAT_NUM_DEF
) (
   input  logic                     wb_clk,
   input  logic                     por_rst,
   input  logic                     pps_i,
   input  logic                     button_i,
   input  logic                     aux_ld1_i,
   input  logic                     aux_ld2_i,
   // Wishbone slave
   input  umtrx_ctrl_pkg::wb_addr_t wb_adr_i,
   input  umtrx_ctrl_pkg::wb_data_t wb_dat_i,
   input  logic                     wb_we_i,
   input  logic                     wb_stb_i,
   input  logic                     wb_cyc_i,
   output umtrx_ctrl_pkg::wb_data_t wb_dat_o,
   output logic                     wb_ack_o,
   // Board pins
   output logic [7:0]               leds_o,
   output logic [1:0]               lms_res_o,
   output logic                     phy_resetn_o,
   output logic                     divsw1_o,
   output logic                     divsw2_o,
   output logic                     boot_done_o
);
   import umtrx_ctrl_pkg::*;

   logic        bus_rst;
   boot_state_t boot_state;
   logic        bldr_done;
   logic        req;
   logic        set_sel, rb_sel, nomap_sel;
   logic        set_ack, rb_ack, nomap_ack_q;
   wb_data_t    rb_dat;
   logic        set_stb;
   set_addr_t   set_addr;
   set_data_t   set_data;
   vita_time_t  vita_time, vita_time_pps;

   ////////////////////
   // Address decode

   assign req       = wb_stb_i & wb_cyc_i;
   assign set_sel   = req && ((wb_adr_i & SETTINGS_MASK) == SETTINGS_REGION);
   assign rb_sel    = req && ((wb_adr_i & READBACK_MASK) == READBACK_REGION);
   assign nomap_sel = req & ~set_sel & ~rb_sel;

   always_ff @(posedge wb_clk) begin  // Unmapped access, ack and ignore
      if (bus_rst) nomap_ack_q <= 1'b0;
      else         nomap_ack_q <= nomap_sel & ~nomap_ack_q;
   end

   assign wb_ack_o    = set_ack | rb_ack | nomap_ack_q;
   assign wb_dat_o    = rb_ack ? rb_dat : '0;  // Settings and unmapped read zero
   assign boot_done_o = (boot_state == BOOT_DONE);

   ////////////////////
   // Blocks

   boot_reset_ctrl i_boot_reset_ctrl (
      .wb_clk(wb_clk), .por_rst(por_rst), .bldr_done_i(bldr_done),
      .bus_rst_o(bus_rst), .boot_state_o(boot_state));

   settings_regs #(.MISC_BASE(MISC_BASE), .DIVSW_BASE(DIVSW_BASE)) i_settings_regs (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_we_i(wb_we_i), .sel_i(set_sel),
      .wb_ack_o(set_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .leds_o(leds_o), .lms_res_o(lms_res_o), .phy_resetn_o(phy_resetn_o),
      .divsw1_o(divsw1_o), .divsw2_o(divsw2_o), .bldr_done_o(bldr_done));

   vita_timer #(.TIME_BASE(TIME_BASE)) i_vita_timer (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst), .pps_i(pps_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   readback_mux #(.COMPAT_NUM(COMPAT_NUM)) i_readback_mux (
      .wb_clk(wb_clk), .bus_rst_i(bus_rst), .sel_i(rb_sel), .wb_adr_i(wb_adr_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .status_bits_i({aux_ld2_i, aux_ld1_i, button_i}),
      .wb_dat_o(rb_dat), .wb_ack_o(rb_ack));

endmodule

/* tb_umtrx_ctrl.sv */
// Testbench for the control core, acting as the Wishbone master
// LCG stimulus, reference readback model, typed compare tasks and report
`timescale 1ns/1ps

module tb_umtrx_ctrl;
   import umtrx_ctrl_pkg::*;

   localparam int       ACK_TIMEOUT  = 20;               // Cycles per bus access
   localparam int       BOOT_TIMEOUT = 20;
   localparam wb_data_t COMPAT_EXP   = {16'd9, 16'd0};   // Major 9 high, minor 0

   logic       wb_clk, por_rst, pps_i;
   logic       button_i, aux_ld1_i, aux_ld2_i;
   wb_addr_t   wb_adr_i;
   wb_data_t   wb_dat_i, wb_dat_o;
   logic       wb_we_i, wb_stb_i, wb_cyc_i, wb_ack_o;
   logic [7:0] leds_o;
   logic [1:0] lms_res_o;
   logic       phy_resetn_o, divsw1_o, divsw2_o, boot_done_o;

   logic [31:0] seed = 32'h7b1b;
   int          err_cnt = 0;
   int          chk_cnt = 0;
   logic        timed_out = 1'b0;    // Set once, later steps skip
   // Model of the board pins and readback sources
   logic [7:0]  exp_led;
   logic [1:0]  exp_lms;
   logic        exp_phyn, exp_dsw1, exp_dsw2;
   vita_time_t  last_load = '0;
   vita_time_t  last_pps = '0;
   logic [2:0]  status = '0;         // aux_ld2, aux_ld1, button

   umtrx_ctrl_top i_umtrx_ctrl_top (.*);

   initial begin
      wb_clk = 1'b0;
      forever #50 wb_clk = ~wb_clk;  // 100 ns period
   end

   ////////////////////
   // Helpers

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;  // 32-bit LCG
      return seed;
   endfunction

   function automatic wb_addr_t sr_adr(input int word);
      return SETTINGS_REGION | wb_addr_t'(word << 2);
   endfunction

   function automatic wb_addr_t rb_adr(input int word);
      return READBACK_REGION | wb_addr_t'(word << 2);
   endfunction

   // Reference readback word
   function automatic wb_data_t expected_word(input int word);
      case (word)
         10:      return last_load[63:32];
         11:      return last_load[31:0];   // Lower bound, time keeps counting
         12:      return COMPAT_EXP;
         13:      return wb_data_t'(status) << 16;
         14:      return last_pps[63:32];
         15:      return last_pps[31:0];
         default: return '0;
      endcase
   endfunction

   task automatic compare_word(input string name, input wb_data_t got, input wb_data_t exp);
      if (timed_out) return;
      chk_cnt++;
      if (got !== exp) begin
         $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_state(input boot_state_t got, input boot_state_t exp);
      if (timed_out) return;
      chk_cnt++;
      if (got !== exp) begin
         $display("ERROR boot_done_o: got 0x%0h (%s), expected 0x%0h (%s)",
                  got, got.name(), exp, exp.name());
         err_cnt++;
      end
   endtask

   task automatic compare_pins();
      compare_word("leds_o", wb_data_t'(leds_o), wb_data_t'(exp_led));
      compare_word("lms_res_o", wb_data_t'(lms_res_o), wb_data_t'(exp_lms));
      compare_word("phy_resetn_o", wb_data_t'(phy_resetn_o), wb_data_t'(exp_phyn));
      compare_word("divsw1_o", wb_data_t'(divsw1_o), wb_data_t'(exp_dsw1));
      compare_word("divsw2_o", wb_data_t'(divsw2_o), wb_data_t'(exp_dsw2));
   endtask

   task automatic wait_ack(input string what);
      int n;
      n = 0;
      @(posedge wb_clk);
      while (wb_ack_o !== 1'b1 && n < ACK_TIMEOUT) begin
         @(posedge wb_clk);
         n++;
      end
      if (wb_ack_o !== 1'b1) begin
         $display("Timeout: no Wishbone ack for the %s", what);
         timed_out = 1'b1;
      end
   endtask

   task automatic write_reg(input wb_addr_t adr, input wb_data_t dat);
      if (timed_out) return;
      @(posedge wb_clk);
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      wb_we_i  <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_cyc_i <= 1'b1;
      wait_ack($sformatf("write to 0x%04h", adr));
      wb_stb_i <= 1'b0;   // Drop after ack
      wb_cyc_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic read_word(input wb_addr_t adr, output wb_data_t dat);
      dat = '0;
      if (timed_out) return;
      @(posedge wb_clk);
      wb_adr_i <= adr;
      wb_we_i  <= 1'b0;
      wb_stb_i <= 1'b1;
      wb_cyc_i <= 1'b1;
      wait_ack($sformatf("read from 0x%04h", adr));
      dat = wb_dat_o;     // Valid with ack
      wb_stb_i <= 1'b0;
      wb_cyc_i <= 1'b0;
   endtask

   task automatic log_result(input int num, input string what, input int errs_before);
      if (timed_out)
         $display("Test %0d %s: stopped by timeout", num, what);
      else if (err_cnt == errs_before)
         $display("Test %0d %s: ok", num, what);
      else
         $display("Test %0d %s: %0d errors", num, what, err_cnt - errs_before);
   endtask

   ////////////////////
   // Tests

   task automatic reset_values();
      int errs;
      errs     = err_cnt;
      exp_led  = 8'h00;
      exp_lms  = 2'b00;
      exp_phyn = 1'b1;    // PHY out of reset
      exp_dsw1 = 1'b1;
      exp_dsw2 = 1'b1;
      compare_pins();
      compare_word("wb_ack_o", wb_data_t'(wb_ack_o), '0);
      check_state(boot_state_t'(boot_done_o), BOOT_WAIT);
      log_result(1, "reset values", errs);
   endtask

   task automatic pin_writes();
      int       errs;
      wb_data_t d;
      wb_addr_t adr;
      errs = err_cnt;
      for (int i = 0; i < 8; i++) begin
         d = next_rand();
         write_reg(sr_adr(SR_MISC_DEF + OFS_CLK), d);
         exp_lms = d[6:5];
         d = next_rand();
         write_reg(sr_adr(SR_MISC_DEF + OFS_LED), d);
         exp_led = d[7:0];
         d = next_rand();
         write_reg(sr_adr(SR_MISC_DEF + OFS_PHY), d);
         exp_phyn = ~d[0];          // Register bit is an active high reset
         d = next_rand();
         write_reg(sr_adr(SR_DIVSW_DEF + OFS_DIVSW1), d);
         exp_dsw1 = d[0];
         d = next_rand();
         write_reg(sr_adr(SR_DIVSW_DEF + OFS_DIVSW2), d);
         exp_dsw2 = d[0];
         compare_pins();
      end
      for (int i = 0; i < 4; i++) begin  // Unmapped, top nibble 1
         d   = next_rand();
         adr = 16'h1000 | wb_addr_t'(d[11:0] & 12'hFFC);
         write_reg(adr, next_rand());
         read_word(adr, d);
         compare_word("wb_dat_o unmapped", d, '0);
         compare_pins();
      end
      log_result(2, "board pin writes", errs);
   endtask

   task automatic status_readback();
      int       errs;
      wb_data_t d;
      errs = err_cnt;
      for (int i = 0; i < 6; i++) begin
         d = next_rand();
         @(posedge wb_clk);
         button_i  <= d[0];
         aux_ld1_i <= d[1];
         aux_ld2_i <= d[2];
         status = d[2:0];
         read_word(rb_adr(12), d);
         compare_word("compat word", d, expected_word(12));
         read_word(rb_adr(13), d);
         compare_word("status word", d, expected_word(13));
      end
      for (int w = 0; w < 10; w++) begin
         read_word(rb_adr(w), d);
         compare_word($sformatf("readback word %0d", w), d, expected_word(w));
      end
      log_result(3, "readback words", errs);
   endtask

   task automatic immediate_load();
      int          errs;
      logic [31:0] hi, lo, lo_min;
      wb_data_t    d;
      errs = err_cnt;
      hi   = next_rand();
      lo   = next_rand() & 32'h7FFF_FFFF;  // Far from a carry into the high half
      write_reg(sr_adr(SR_TIME64_DEF + OFS_TIME_IMM), 32'd1);
      write_reg(sr_adr(SR_TIME64_DEF + OFS_TIME_HI), hi);
      write_reg(sr_adr(SR_TIME64_DEF + OFS_TIME_LO), lo);
      last_load = {hi, lo};
      read_word(rb_adr(10), d);
      compare_word("time hi", d, expected_word(10));
      read_word(rb_adr(10), d);
      compare_word("time hi", d, expected_word(10));
      read_word(rb_adr(11), d);
      lo_min = expected_word(11) + 32'd1;
      if (!timed_out) begin
         chk_cnt++;
         if (d < lo_min || d > lo_min + 32'd19) begin
            $display("ERROR time lo: got 0x%08h, expected 0x%08h to 0x%08h",
                     d, lo_min, lo_min + 32'd19);
            err_cnt++;
         end
      end
      log_result(4, "immediate time load", errs);
   endtask

   task automatic pps_load();
      int          errs;
      logic [31:0] hi, lo;
      wb_data_t    d;
      errs = err_cnt;
      hi   = next_rand();
      if (hi == last_load[63:32]) hi = hi ^ 32'd1;  // Must differ from running time
      lo   = next_rand() & 32'h7FFF_FFFF;
      write_reg(sr_adr(SR_TIME64_DEF + OFS_TIME_IMM), 32'd0);  // Arm for PPS
      write_reg(sr_adr(SR_TIME64_DEF + OFS_TIME_HI), hi);
      write_reg(sr_adr(SR_TIME64_DEF + OFS_TIME_LO), lo);
      read_word(rb_adr(10), d);
      compare_word("time hi before pps", d, expected_word(10));  // Old load still runs
      @(posedge wb_clk);
      pps_i <= 1'b1;
      repeat (5) @(posedge wb_clk);  // Edge acted on 3 cycles after the rise
      pps_i <= 1'b0;
      last_load = {hi, lo};
      last_pps  = {hi, lo};
      read_word(rb_adr(14), d);
      compare_word("pps time hi", d, expected_word(14));
      read_word(rb_adr(15), d);
      compare_word("pps time lo", d, expected_word(15));
      read_word(rb_adr(10), d);
      compare_word("time hi after pps", d, expected_word(10));
      log_result(5, "PPS time load", errs);
   endtask

   task automatic boot_handover();
      int errs;
      int n;
      errs = err_cnt;
      write_reg(sr_adr(SR_MISC_DEF + OFS_LED), 32'h0000_00A5);
      write_reg(sr_adr(SR_MISC_DEF + OFS_CLK), 32'h0000_0060);
      write_reg(sr_adr(SR_DIVSW_DEF + OFS_DIVSW1), 32'd0);
      exp_led  = 8'hA5;
      exp_lms  = 2'b11;
      exp_dsw1 = 1'b0;
      compare_pins();
      check_state(boot_state_t'(boot_done_o), BOOT_WAIT);
      write_reg(sr_adr(SR_MISC_DEF + OFS_BLDR), 32'd1);
      n = 0;
      while (!timed_out && boot_done_o !== 1'b1 && n < BOOT_TIMEOUT) begin
         @(posedge wb_clk);
         n++;
      end
      if (!timed_out && boot_done_o !== 1'b1) begin
         $display("Timeout: boot_done_o never rose after the bootloader-done write");
         timed_out = 1'b1;
      end
      @(posedge wb_clk);             // Bus reset pulse clears the registers
      exp_led  = 8'h00;
      exp_lms  = 2'b00;
      exp_phyn = 1'b1;
      exp_dsw1 = 1'b1;
      exp_dsw2 = 1'b1;
      compare_pins();
      check_state(boot_state_t'(boot_done_o), BOOT_DONE);
      write_reg(sr_adr(SR_MISC_DEF + OFS_BLDR), 32'd1);  // Second handover request
      for (int i = 0; i < 4; i++) begin
         @(posedge wb_clk);
         check_state(boot_state_t'(boot_done_o), BOOT_DONE);
      end
      log_result(6, "bootloader handover", errs);
   endtask

   ////////////////////
   // Main sequence

   initial begin
      por_rst   = 1'b1;
      pps_i     = 1'b0;
      button_i  = 1'b0;
      aux_ld1_i = 1'b0;
      aux_ld2_i = 1'b0;
      wb_adr_i  = '0;
      wb_dat_i  = '0;
      wb_we_i   = 1'b0;
      wb_stb_i  = 1'b0;
      wb_cyc_i  = 1'b0;
      repeat (3) @(posedge wb_clk);
      por_rst <= 1'b0;
      repeat (2) @(posedge wb_clk);  // Bus reset lasts one cycle past por_rst
      reset_values();
      pin_writes();
      status_readback();
      immediate_load();
      pps_load();
      boot_handover();
      $display("Summary: %0d checks, %0d errors, timeout %0d", chk_cnt, err_cnt, timed_out);
      if (err_cnt == 0 && !timed_out) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* umtrx_ctrl.f */
umtrx_ctrl_pkg.sv
boot_reset_ctrl.sv
vita_timer.sv
settings_regs.sv
readback_mux.sv
umtrx_ctrl_top.sv
tb_umtrx_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the control core testbench with Verilator.
# Pass or fail comes from the pass line in the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -j 0 \
   --top-module tb_umtrx_ctrl --Mdir "$BUILD_DIR" -f umtrx_ctrl.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vtb_umtrx_ctrl" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1
